// ==== spi_reg_pkg.sv ====
// shared types and constants for the SPI register bank
// the address width follows REG_COUNT, which must stay a power of two
`default_nettype none

package spi_reg_pkg;

    // number of registers in the map, address 0 is the read-only id
    localparam int REG_COUNT = 8;

    // one SPI byte, also the width of every register
    typedef logic [7:0] reg_data_t;

    // register address, wraps modulo REG_COUNT when incremented
    typedef logic [$clog2(REG_COUNT)-1:0] reg_addr_t;

    // value returned for reads of address 0
    localparam reg_data_t REG_ID_VALUE = 8'hA5;

    // bit of the command byte that selects a write frame
    localparam int CMD_WRITE_BIT = 7;

    // frame controller states
    // FS_RD_FETCH has a bus read in flight, FS_RD_WAIT holds the fetched
    // byte until the slave takes it, FS_STREAM waits for the next byte
    typedef enum logic [2:0] {
        FS_IDLE,
        FS_CMD,
        FS_WR_DATA,
        FS_RD_FETCH,
        FS_RD_WAIT,
        FS_STREAM
    } frame_state_t;

endpackage

`default_nettype wire

// ==== spi_byte_if.sv ====
// byte-level link between the SPI slave and the frame controller
// all signals are in the clk domain, pulses last one cycle
`timescale 1ns/1ps
`default_nettype none

interface spi_byte_if;
    import spi_reg_pkg::*;

    // received byte, valid in the cycle rx_valid is high
    reg_data_t rx_byte;
    logic      rx_valid;
    // high while select is low, after synchronization
    logic      frame_active;
    // byte that the slave loads at the next byte boundary
    reg_data_t tx_byte;
    // pulses when the slave copies tx_byte into its shift register
    logic      tx_taken;

    modport slave (
        output rx_byte, rx_valid, frame_active, tx_taken,
        input  tx_byte
    );

    modport master (
        input  rx_byte, rx_valid, frame_active, tx_taken,
        output tx_byte
    );

endinterface

`default_nettype wire

// ==== wb_bus_if.sv ====
// internal Wishbone classic bus, no err, rty or sel lines
`timescale 1ns/1ps
`default_nettype none

interface wb_bus_if;
    import spi_reg_pkg::*;

    logic      cyc;
    logic      stb;
    logic      we;
    reg_addr_t adr;
    reg_data_t dat_w;
    reg_data_t dat_r;
    logic      ack;

    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

`default_nettype wire

// ==== spi_slave.sv ====
// SPI mode 0 slave that oversamples the pins with clk
// each SPI clock phase must last at least 6 clk cycles
// MISO is driven low outside a frame and never tri-stated
`timescale 1ns/1ps
`default_nettype none

module spi_slave (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       spi_clk,
    input  logic       spi_ss_n,
    input  logic       spi_mosi,
    output logic       spi_miso,
    spi_byte_if.slave  bytes
);
    import spi_reg_pkg::*;

    // two-flop synchronizers, index 1 is the stable copy
    logic [1:0] clk_sync;
    logic [1:0] ss_sync;
    logic [1:0] mosi_sync;
    // previous synchronized SPI clock, for edge detection
    logic       clk_prev;
    logic       active;
    logic [2:0] bit_cnt;
    reg_data_t  rx_shift;
    reg_data_t  tx_shift;
    logic       rx_valid_q;
    logic       tx_taken_q;
    logic       clk_rise;
    logic       clk_fall;
    logic       in_frame;

    // edges are decided one cycle after the synchronizer output moves
    assign clk_rise = clk_sync[1] & ~clk_prev;
    assign clk_fall = ~clk_sync[1] & clk_prev;
    assign in_frame = ~ss_sync[1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clk_sync  <= 2'b00;
            // select idles high, so the synchronizer starts there too
            ss_sync   <= 2'b11;
            mosi_sync <= 2'b00;
            clk_prev  <= 1'b0;
        end else begin
            clk_sync  <= {clk_sync[0], spi_clk};
            ss_sync   <= {ss_sync[0], spi_ss_n};
            mosi_sync <= {mosi_sync[0], spi_mosi};
            clk_prev  <= clk_sync[1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active     <= 1'b0;
            bit_cnt    <= '0;
            rx_shift   <= '0;
            tx_shift   <= '0;
            rx_valid_q <= 1'b0;
            tx_taken_q <= 1'b0;
        end else begin
            // active and the pulses come from the same in_frame sample, so
            // a pulse is never seen outside frame_active
            active     <= in_frame;
            rx_valid_q <= 1'b0;
            tx_taken_q <= 1'b0;
            if (!in_frame) begin
                // between frames everything returns to its idle value and
                // a partial byte is thrown away
                bit_cnt  <= '0;
                rx_shift <= '0;
                tx_shift <= '0;
            end else if (clk_rise) begin
                // sample MOSI, the eighth bit completes the byte
                rx_shift <= {rx_shift[6:0], mosi_sync[1]};
                bit_cnt  <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    rx_valid_q <= 1'b1;
                end
            end else if (clk_fall) begin
                // a falling edge with the counter back at zero is the
                // eighth one of a byte, so the next byte gets loaded
                if (bit_cnt == 3'd0) begin
                    tx_shift   <= bytes.tx_byte;
                    tx_taken_q <= 1'b1;
                end else begin
                    tx_shift <= {tx_shift[6:0], 1'b0};
                end
            end
        end
    end

    // the receive register already holds the full byte when rx_valid is set
    assign bytes.rx_byte      = rx_shift;
    assign bytes.rx_valid     = rx_valid_q;
    assign bytes.frame_active = active;
    assign bytes.tx_taken     = tx_taken_q;

    // MSB first, the master samples it on the next rising edge
    assign spi_miso = tx_shift[7];

endmodule

`default_nettype wire

// ==== spi_frame_ctrl.sv ====
// turns the SPI byte stream into Wishbone accesses, command byte first
// bit 7 of the command selects write, the low bits give the start address
// relies on every bus cycle ending before the next byte boundary
`timescale 1ns/1ps
`default_nettype none

module spi_frame_ctrl (
    input  logic        clk,
    input  logic        arst_n,
    spi_byte_if.master  bytes,
    wb_bus_if.master    bus
);
    import spi_reg_pkg::*;

    frame_state_t state;
    // current register address of the frame
    reg_addr_t    addr;
    // cyc and stb move together in this master
    logic         bus_req;
    logic         bus_we;
    reg_addr_t    bus_adr;
    reg_data_t    bus_dat_w;
    reg_data_t    tx_data;
    logic         bus_done;
    logic         start_wr;
    logic         start_rd;
    reg_addr_t    rd_addr;

    assign bus_done = bus_req & bus.ack;

    // a data byte of a write frame starts a write at the current address
    assign start_wr = bytes.rx_valid && (state == FS_WR_DATA);

    // a read command or a finished read byte starts the next prefetch
    always_comb begin
        start_rd = 1'b0;
        rd_addr  = addr;
        if (bytes.rx_valid) begin
            if (state == FS_CMD && !bytes.rx_byte[CMD_WRITE_BIT]) begin
                start_rd = 1'b1;
                rd_addr  = reg_addr_t'(bytes.rx_byte);
            end else if (state == FS_STREAM) begin
                start_rd = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= FS_IDLE;
            addr    <= '0;
            bus_req <= 1'b0;
            tx_data <= '0;
        end else begin
            // ack lasts one cycle and the request drops right after it
            if (bus_done) begin
                bus_req <= 1'b0;
            end
            if (start_wr || start_rd) begin
                bus_req <= 1'b1;
            end

            case (state)
                FS_IDLE: begin
                    // MISO carries zeros during the command byte
                    tx_data <= '0;
                    if (bytes.frame_active) begin
                        state <= FS_CMD;
                    end
                end
                FS_CMD: begin
                    if (bytes.rx_valid) begin
                        addr <= reg_addr_t'(bytes.rx_byte);
                        if (bytes.rx_byte[CMD_WRITE_BIT]) begin
                            state <= FS_WR_DATA;
                        end else begin
                            state <= FS_RD_FETCH;
                        end
                    end
                end
                FS_WR_DATA: begin
                    // move on once the register has taken the byte
                    if (bus_done) begin
                        addr <= addr + reg_addr_t'(1);
                    end
                end
                FS_RD_FETCH: begin
                    if (bus_done) begin
                        tx_data <= bus.dat_r;
                        state   <= FS_RD_WAIT;
                    end
                end
                FS_RD_WAIT: begin
                    // the slave now shifts this byte out, so the address
                    // can advance for the next prefetch
                    if (bytes.tx_taken) begin
                        addr  <= addr + reg_addr_t'(1);
                        state <= FS_STREAM;
                    end
                end
                FS_STREAM: begin
                    if (start_rd) begin
                        state <= FS_RD_FETCH;
                    end
                end
                default: begin
                    state <= FS_IDLE;
                end
            endcase

            // select went high, leave once no bus cycle is in flight
            if (!bytes.frame_active && !bus_req && state != FS_IDLE) begin
                state <= FS_IDLE;
            end
        end
    end

    // address, data and direction are only looked at while cyc is high
    always_ff @(posedge clk) begin
        if (start_wr) begin
            bus_we    <= 1'b1;
            bus_adr   <= addr;
            bus_dat_w <= bytes.rx_byte;
        end else if (start_rd) begin
            bus_we  <= 1'b0;
            bus_adr <= rd_addr;
        end
    end

    assign bus.cyc       = bus_req;
    assign bus.stb       = bus_req;
    assign bus.we        = bus_we;
    assign bus.adr       = bus_adr;
    assign bus.dat_w     = bus_dat_w;
    assign bytes.tx_byte = tx_data;

endmodule

`default_nettype wire

// ==== spi_reg_file.sv ====
// eight 8-bit registers on a Wishbone classic slave port
// address 0 reads as the id value and ignores writes
`timescale 1ns/1ps
`default_nettype none

module spi_reg_file (
    input  logic      clk,
    input  logic      arst_n,
    wb_bus_if.slave   bus
);
    import spi_reg_pkg::*;

    // address 0 has no storage behind it
    reg_data_t regs [1:REG_COUNT-1];
    logic      ack_q;
    reg_data_t dat_r_q;
    reg_data_t rd_data;
    logic      req;

    // a new request is one that has not been acknowledged yet
    assign req = bus.cyc & bus.stb & ~ack_q;

    always_comb begin
        rd_data = REG_ID_VALUE;
        for (int k = 1; k < REG_COUNT; k++) begin
            if (bus.adr == reg_addr_t'(k)) begin
                rd_data = regs[k];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q <= 1'b0;
        end else begin
            // one cycle after strobe, and never two in a row
            ack_q <= req;
        end
    end

    // the write lands at the end of the ack cycle, when the transfer
    // completes on the bus
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 1; k < REG_COUNT; k++) begin
                regs[k] <= '0;
            end
        end else if (bus.cyc && bus.stb && bus.we && ack_q) begin
            for (int k = 1; k < REG_COUNT; k++) begin
                if (bus.adr == reg_addr_t'(k)) begin
                    regs[k] <= bus.dat_w;
                end
            end
        end
    end

    // read data is valid together with ack
    always_ff @(posedge clk) begin
        if (req) begin
            dat_r_q <= rd_data;
        end
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = dat_r_q;

endmodule

`default_nettype wire

// ==== spi_reg_top.sv ====
// SPI mode 0 register bank, eight registers reached only over SPI
// each SPI clock phase must last at least 6 clk cycles
`timescale 1ns/1ps
`default_nettype none

module spi_reg_top (
    input  logic clk,
    input  logic arst_n,
    input  logic spi_clk,
    input  logic spi_ss_n,
    input  logic spi_mosi,
    output logic spi_miso
);

    spi_byte_if u_bytes ();
    wb_bus_if   u_bus ();

    // pin side, byte framing and MISO shifting
    spi_slave u_spi_slave (
        .clk      (clk),
        .arst_n   (arst_n),
        .spi_clk  (spi_clk),
        .spi_ss_n (spi_ss_n),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .bytes    (u_bytes.slave)
    );

    // command decode and bus master
    spi_frame_ctrl u_frame_ctrl (
        .clk    (clk),
        .arst_n (arst_n),
        .bytes  (u_bytes.master),
        .bus    (u_bus.master)
    );

    spi_reg_file u_reg_file (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (u_bus.slave)
    );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
// testbench clock with a 100 ns period, reset held low for 5 rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== spi_reg_checker.sv ====
// bus and byte-link rules of the frame controller, bound into spi_frame_ctrl
// only active while reset is released
`timescale 1ns/1ps
`default_nettype none

module spi_reg_checker (
    input logic                  clk,
    input logic                  arst_n,
    input logic                  cyc,
    input logic                  stb,
    input spi_reg_pkg::reg_addr_t adr,
    input logic                  ack,
    input logic                  rx_valid,
    input logic                  frame_active
);
    import spi_reg_pkg::*;

    // a strobe outside a bus cycle is not a legal Wishbone transfer
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!arst_n)
        stb |-> cyc)
        else $error("stb high while cyc is low");

    // the request and its address hold until the slave answers
    a_hold_until_ack: assert property (@(posedge clk) disable iff (!arst_n)
        (stb && !ack) |=> (stb && $stable(adr)))
        else $error("stb or adr changed before ack");

    a_ack_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        ack |=> !ack)
        else $error("ack high for two cycles");

    // bytes can only complete inside a frame
    a_rx_in_frame: assert property (@(posedge clk) disable iff (!arst_n)
        rx_valid |-> frame_active)
        else $error("rx_valid outside a frame");

endmodule

bind spi_frame_ctrl spi_reg_checker u_checker (
    .clk          (clk),
    .arst_n       (arst_n),
    .cyc          (bus.cyc),
    .stb          (bus.stb),
    .adr          (bus.adr),
    .ack          (bus.ack),
    .rx_valid     (bytes.rx_valid),
    .frame_active (bytes.frame_active)
);

`default_nettype wire

// ==== spi_reg_tb.sv ====
// drives SPI mode 0 frames with 8 clk cycles per SPI clock phase
// every read byte is checked against a register model kept here
`timescale 1ns/1ps
`default_nettype none

module spi_reg_tb;
    import spi_reg_pkg::*;

    // frames over all tests, and the longest frame (command plus 9 bytes)
    localparam int NUM_FRAMES     = 223;
    localparam int FRAME_CYCLES   = 10 * 8 * 16 + 17;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_CYCLES + 2000;

    logic      clk;
    logic      arst_n;
    logic      spi_clk;
    logic      spi_ss_n;
    logic      spi_mosi;
    logic      spi_miso;
    int        seed = 32'h7d9b4b4c;
    int        check_cnt;
    int        err_cnt;
    int        err_base;
    int        cycle_cnt;
    reg_data_t model [REG_COUNT];
    // bytes sent on MOSI and bytes seen on MISO in the last frame
    reg_data_t tx_q [$];
    reg_data_t rx_q [$];

    tb_clock_gen u_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    spi_reg_top u_dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .spi_clk  (spi_clk),
        .spi_ss_n (spi_ss_n),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    function automatic reg_data_t rand_byte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // uniform enough in 0 to n-1 for small n
    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return int'({1'b0, r[30:0]} % n);
    endfunction

    task automatic compare_byte(input reg_data_t got, input reg_data_t exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t: %s returned %h, expected %h", $time, what, got, exp);
        end
    endtask

    // one frame from tx_q, MSB first, cut_bits above 0 stops the last byte early
    task automatic shift_frame(input int cut_bits);
        reg_data_t out_b;
        reg_data_t in_b;
        int        n_bits;
        rx_q.delete();
        @(posedge clk);
        spi_ss_n <= 1'b0;
        foreach (tx_q[b]) begin
            out_b  = tx_q[b];
            in_b   = 8'h00;
            n_bits = 8;
            if (b == tx_q.size() - 1 && cut_bits > 0) begin
                n_bits = cut_bits;
            end
            for (int i = 0; i < n_bits; i++) begin
                spi_mosi <= out_b[7];
                out_b = {out_b[6:0], 1'b0};
                repeat (8) @(posedge clk);
                // MISO moved 3 cycles after the last falling edge and is settled
                in_b = {in_b[6:0], spi_miso};
                spi_clk <= 1'b1;
                repeat (8) @(posedge clk);
                spi_clk <= 1'b0;
            end
            rx_q.push_back(in_b);
        end
        repeat (8) @(posedge clk);
        spi_ss_n <= 1'b1;
        spi_mosi <= 1'b0;
        repeat (8) @(posedge clk);
    endtask

    task automatic write_frame(input reg_addr_t start, input int len);
        reg_data_t cmd;
        reg_data_t d;
        reg_addr_t a;
        cmd = reg_data_t'(start);
        cmd[CMD_WRITE_BIT] = 1'b1;
        tx_q.delete();
        tx_q.push_back(cmd);
        for (int j = 0; j < len; j++) begin
            d = rand_byte();
            a = reg_addr_t'(start + j);
            tx_q.push_back(d);
            // the id register keeps its value
            if (a != 3'd0) begin
                model[a] = d;
            end
        end
        shift_frame(0);
    endtask

    task automatic read_frame(input reg_addr_t start, input int len);
        reg_addr_t a;
        tx_q.delete();
        tx_q.push_back(reg_data_t'(start));
        for (int j = 0; j < len; j++) begin
            tx_q.push_back(rand_byte());
        end
        shift_frame(0);
        compare_byte(rx_q[0], 8'h00, "MISO during the command byte");
        for (int j = 0; j < len; j++) begin
            a = reg_addr_t'(start + j);
            compare_byte(rx_q[j + 1], model[a], $sformatf("read of address %0d", a));
        end
    endtask

    task automatic report_test(input string name);
        $display("%s done, %0d errors", name, err_cnt - err_base);
        err_base = err_cnt;
    endtask

    initial begin
        reg_addr_t a;
        int        len;
        reg_data_t d;
        spi_clk   = 1'b0;
        spi_ss_n  = 1'b1;
        spi_mosi  = 1'b0;
        check_cnt = 0;
        err_cnt   = 0;
        err_base  = 0;
        foreach (model[i]) begin
            model[i] = 8'h00;
        end
        model[0] = REG_ID_VALUE;
        wait (arst_n === 1'b1);
        repeat (4) @(posedge clk);

        read_frame(3'd0, 8);
        report_test("reset burst read");

        repeat (8) begin
            a = reg_addr_t'(1 + rand_below(7));
            write_frame(a, 1);
            read_frame(a, 1);
        end
        report_test("single write and read");

        // start at 5 to 7 and run at least one byte past address 7
        a   = reg_addr_t'(5 + rand_below(3));
        len = REG_COUNT - int'(a) + 1 + rand_below(4);
        write_frame(a, len);
        read_frame(3'd0, 8);
        report_test("wrapping burst write");

        write_frame(3'd0, 2);
        read_frame(3'd0, 2);
        report_test("write to id register");

        // half a data byte, then select goes high
        a = reg_addr_t'(1 + rand_below(7));
        d = reg_data_t'(a);
        d[CMD_WRITE_BIT] = 1'b1;
        tx_q.delete();
        tx_q.push_back(d);
        tx_q.push_back(~model[a]);
        shift_frame(4);
        read_frame(a, 1);
        report_test("aborted write frame");

        repeat (200) begin
            a   = reg_addr_t'(rand_below(REG_COUNT));
            len = 1 + rand_below(9);
            if (rand_below(2) == 1) begin
                write_frame(a, len);
            end else begin
                read_frame(a, len);
            end
        end
        report_test("random mixed frames");

        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the tests did not complete", cycle_cnt);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== spi_reg_top.f ====
spi_reg_pkg.sv
spi_byte_if.sv
wb_bus_if.sv
spi_slave.sv
spi_frame_ctrl.sv
spi_reg_file.sv
spi_reg_top.sv
tb_clock_gen.sv
spi_reg_checker.sv
spi_reg_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and pass only if the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f spi_reg_top.f --top-module spi_reg_tb -o sim_spi_reg &&
./obj_dir/sim_spi_reg | tee /dev/stderr | grep -qx "Finished with no errors" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
